// File: design/rvPkg.sv
package rvPkg;

    // major opcodes of the supported rv32i subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcodeT;

    // alu operation codes, bit 3 stays zero
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_AND  = 4'd1,
        ALU_OR   = 4'd2,
        ALU_SUB  = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6
    } aluOpT;

    // multicycle control states
    // gaps at 11 and 12 are unused
    typedef enum logic [3:0] {
        S_FETCH      = 4'd0,
        S_FETCH_WAIT = 4'd1,
        S_DECODE     = 4'd2,
        S_MEM_ADDR   = 4'd3,
        S_MEM_READ   = 4'd4,
        S_MEM_WRITE  = 4'd5,
        S_EXEC_R     = 4'd6,
        S_WRITEBACK  = 4'd7,
        S_LOAD_WB    = 4'd8,
        S_HALT       = 4'd9,
        S_IDLE       = 4'd10,
        S_EXEC_I     = 4'd13,
        S_BRANCH     = 4'd14
    } ctrlStateT;

    // one word request toward the shared ram
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [29:0] wordAddr;
        logic [31:0] wdata;
    } memReqT;

    // read data return, one cycle after the grant
    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
    } memRspT;

    // host control register, above the largest ram (16k words)
    localparam logic [31:0] CTRL_ADDR = 32'h0001_0000;

endpackage

// File: design/aluControl.sv
module aluControl (
    input  rvPkg::ctrlStateT currentState,
    input  logic [6:0]       opcode,
    input  logic [3:0]       funct,
    output rvPkg::aluOpT     operation
);

    // funct is {inst[30], funct3}
    always_comb begin
        operation = rvPkg::ALU_ADD;
        case (currentState)
            rvPkg::S_EXEC_R: begin
                // register forms use bit 30 to split add and sub
                if (opcode == rvPkg::OP) begin
                    case (funct)
                        4'b0000: operation = rvPkg::ALU_ADD;
                        4'b1000: operation = rvPkg::ALU_SUB;
                        4'b0111: operation = rvPkg::ALU_AND;
                        4'b0110: operation = rvPkg::ALU_OR;
                        4'b0100: operation = rvPkg::ALU_XOR;
                        4'b0010: operation = rvPkg::ALU_SLT;
                        4'b0011: operation = rvPkg::ALU_SLTU;
                        default: operation = rvPkg::ALU_ADD;
                    endcase
                end
            end
            rvPkg::S_EXEC_I: begin
                // bit 30 belongs to the immediate here
                if (opcode == rvPkg::OP_IMM) begin
                    case (funct[2:0])
                        3'b111:  operation = rvPkg::ALU_AND;
                        3'b110:  operation = rvPkg::ALU_OR;
                        3'b100:  operation = rvPkg::ALU_XOR;
                        3'b010:  operation = rvPkg::ALU_SLT;
                        3'b011:  operation = rvPkg::ALU_SLTU;
                        default: operation = rvPkg::ALU_ADD;
                    endcase
                end
            end
            // beq compares by subtracting
            rvPkg::S_BRANCH: operation = rvPkg::ALU_SUB;
            // address calculation and everything else adds
            default: operation = rvPkg::ALU_ADD;
        endcase
    end

endmodule

// File: design/alu.sv
module alu (
    input  logic [31:0]  a,
    input  logic [31:0]  b,
    input  rvPkg::aluOpT operation,
    output logic [31:0]  result,
    output logic         zero
);

    logic lessSigned;
    logic lessUnsigned;

    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (operation)
            rvPkg::ALU_ADD:  result = a + b;
            rvPkg::ALU_SUB:  result = a - b;
            rvPkg::ALU_AND:  result = a & b;
            rvPkg::ALU_OR:   result = a | b;
            rvPkg::ALU_XOR:  result = a ^ b;
            // compares give 0 or 1
            rvPkg::ALU_SLT:  result = {31'd0, lessSigned};
            rvPkg::ALU_SLTU: result = {31'd0, lessUnsigned};
            default:         result = a + b;
        endcase
    end

    // beq taken when a - b is zero
    assign zero = (result == 32'd0);

endmodule

// File: design/controlUnit.sv
module controlUnit (
    input  logic             clock,
    input  logic             rst,
    input  logic             coreRun,
    input  logic [6:0]       opcode,
    input  logic             zero,
    input  logic             memGrant,
    input  logic             memRvalid,
    output rvPkg::ctrlStateT currentState,
    output logic             pcWrite,
    output logic             irWrite,
    output logic             regWrite,
    output logic             aluSrcImm,
    output logic             memToReg,
    output logic             memValid,
    output logic             memWrite,
    output logic             halted
);

    rvPkg::ctrlStateT nextState;
    // load granted, data still on its way
    logic readPending;

    always_ff @(posedge clock) begin
        if (rst) begin
            currentState <= rvPkg::S_IDLE;
            readPending  <= 1'b0;
        end else begin
            currentState <= nextState;
            if (currentState == rvPkg::S_MEM_READ && memGrant) begin
                readPending <= 1'b1;
            end else if (memRvalid) begin
                readPending <= 1'b0;
            end
        end
    end

    always_comb begin
        nextState = currentState;
        case (currentState)
            rvPkg::S_IDLE:       if (coreRun) nextState = rvPkg::S_FETCH;
            // wait for the arbiter, then for the read data
            rvPkg::S_FETCH:      if (memGrant) nextState = rvPkg::S_FETCH_WAIT;
            rvPkg::S_FETCH_WAIT: if (memRvalid) nextState = rvPkg::S_DECODE;
            rvPkg::S_DECODE: begin
                case (opcode)
                    rvPkg::OP:     nextState = rvPkg::S_EXEC_R;
                    rvPkg::OP_IMM: nextState = rvPkg::S_EXEC_I;
                    rvPkg::LOAD:   nextState = rvPkg::S_MEM_ADDR;
                    rvPkg::STORE:  nextState = rvPkg::S_MEM_ADDR;
                    rvPkg::BRANCH: nextState = rvPkg::S_BRANCH;
                    rvPkg::SYSTEM: nextState = rvPkg::S_HALT;
                    // unknown opcodes are skipped
                    default:       nextState = rvPkg::S_FETCH;
                endcase
            end
            rvPkg::S_MEM_ADDR: begin
                if (opcode == rvPkg::STORE) begin
                    nextState = rvPkg::S_MEM_WRITE;
                end else begin
                    nextState = rvPkg::S_MEM_READ;
                end
            end
            rvPkg::S_MEM_READ:  if (readPending && memRvalid) nextState = rvPkg::S_LOAD_WB;
            // writes are done at the grant
            rvPkg::S_MEM_WRITE: if (memGrant) nextState = rvPkg::S_FETCH;
            rvPkg::S_EXEC_R:    nextState = rvPkg::S_WRITEBACK;
            rvPkg::S_EXEC_I:    nextState = rvPkg::S_WRITEBACK;
            rvPkg::S_WRITEBACK: nextState = rvPkg::S_FETCH;
            rvPkg::S_LOAD_WB:   nextState = rvPkg::S_FETCH;
            rvPkg::S_BRANCH:    nextState = rvPkg::S_FETCH;
            // ecall parks the core until reset
            rvPkg::S_HALT:      nextState = rvPkg::S_HALT;
            default:            nextState = rvPkg::S_IDLE;
        endcase
    end

    // state-derived enables
    assign irWrite   = (currentState == rvPkg::S_FETCH_WAIT) && memRvalid;
    assign pcWrite   = irWrite || ((currentState == rvPkg::S_BRANCH) && zero);
    assign regWrite  = (currentState == rvPkg::S_WRITEBACK) ||
                       (currentState == rvPkg::S_LOAD_WB);
    assign aluSrcImm = (currentState == rvPkg::S_EXEC_I) ||
                       (currentState == rvPkg::S_MEM_ADDR);
    // data access states, address comes from the alu result
    assign memToReg  = (currentState == rvPkg::S_MEM_READ) ||
                       (currentState == rvPkg::S_MEM_WRITE) ||
                       (currentState == rvPkg::S_LOAD_WB);
    // load request drops once granted
    assign memValid  = (currentState == rvPkg::S_FETCH) ||
                       ((currentState == rvPkg::S_MEM_READ) && !readPending) ||
                       (currentState == rvPkg::S_MEM_WRITE);
    assign memWrite  = (currentState == rvPkg::S_MEM_WRITE);
    assign halted    = (currentState == rvPkg::S_HALT);

endmodule

// File: design/coreDatapath.sv
module coreDatapath #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic          clock,
    input  logic          rst,
    input  logic          pcWrite,
    input  logic          irWrite,
    input  logic          regWrite,
    input  logic          aluSrcImm,
    input  logic          memToReg,
    input  rvPkg::aluOpT  operation,
    input  rvPkg::memRspT memRsp,
    output logic [29:0]   wordAddr,
    output logic [31:0]   wdata,
    output logic [6:0]    opcode,
    output logic [3:0]    funct,
    output logic          zero
);

    logic [31:0] pc;
    // pc of the instruction in ir, base for branches
    logic [31:0] oldPc;
    logic [31:0] ir;
    logic [31:0] mdr;
    logic [31:0] aluOut;
    logic [31:0] regs [32];
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] rs1Val;
    logic [31:0] rs2Val;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] aluB;
    logic [31:0] aluResult;

    // instruction fields
    assign opcode = ir[6:0];
    assign funct  = {ir[30], ir[14:12]};
    assign rd     = ir[11:7];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];

    // x0 always reads zero
    assign rs1Val = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2Val = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

    // sign-extended immediates
    assign immI = {{20{ir[31]}}, ir[31:20]};
    assign immS = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign immB = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};

    // stores take the s-form offset
    assign aluB = !aluSrcImm ? rs2Val :
                  (opcode == rvPkg::STORE) ? immS : immI;

    alu alu0 (
        .a        (rs1Val),
        .b        (aluB),
        .operation(operation),
        .result   (aluResult),
        .zero     (zero)
    );

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= resetPc;
        end else if (irWrite) begin
            pc <= pc + 32'd4;
        end else if (pcWrite) begin
            // taken beq
            pc <= oldPc + immB;
        end
    end

    always_ff @(posedge clock) begin
        if (irWrite) begin
            ir    <= memRsp.rdata;
            oldPc <= pc;
        end
        if (memToReg && memRsp.rvalid) begin
            mdr <= memRsp.rdata;
        end
        // frozen while the data access uses it as address
        if (!memToReg) begin
            aluOut <= aluResult;
        end
        if (regWrite && rd != 5'd0) begin
            regs[rd] <= memToReg ? mdr : aluOut;
        end
    end

    // fetch from pc, data access from the computed address
    assign wordAddr = memToReg ? aluOut[31:2] : pc[31:2];
    assign wdata    = rs2Val;

endmodule

// File: design/memArbiter.sv
module memArbiter (
    input  logic          clock,
    input  logic          rst,
    input  rvPkg::memReqT coreReq,
    input  rvPkg::memReqT hostReq,
    input  logic [31:0]   ramRdata,
    output logic          coreGrant,
    output logic          hostGrant,
    output rvPkg::memRspT coreRsp,
    output rvPkg::memRspT hostRsp,
    output rvPkg::memReqT ramReq
);

    // last grant pointer, set so the host wins first
    logic lastWasCore;
    // read issued last cycle and its owner
    logic readPending;
    logic readForHost;

    // on a tie the requester not granted last time wins
    assign coreGrant = coreReq.valid && (!hostReq.valid || !lastWasCore);
    assign hostGrant = hostReq.valid && !coreGrant;

    assign ramReq = hostGrant ? hostReq :
                    coreGrant ? coreReq : '0;

    always_ff @(posedge clock) begin
        if (rst) begin
            lastWasCore <= 1'b1;
            readPending <= 1'b0;
            readForHost <= 1'b0;
        end else begin
            if (coreGrant || hostGrant) begin
                lastWasCore <= coreGrant;
            end
            readPending <= ramReq.valid && !ramReq.write;
            readForHost <= hostGrant;
        end
    end

    // return path, data shared and rvalid steered
    assign coreRsp = '{rvalid: readPending && !readForHost, rdata: ramRdata};
    assign hostRsp = '{rvalid: readPending && readForHost, rdata: ramRdata};

endmodule

// File: design/sharedRam.sv
module sharedRam #(
    parameter int memAddrBits = 10
) (
    input  logic          clock,
    input  rvPkg::memReqT req,
    output logic [31:0]   rdata
);

    logic [31:0] mem [2**memAddrBits];
    logic [memAddrBits-1:0] addr;

    // upper word address bits are ignored
    assign addr = req.wordAddr[memAddrBits-1:0];

    always_ff @(posedge clock) begin
        if (req.valid && req.write) begin
            mem[addr] <= req.wdata;
        end
        // registered read, one cycle of latency
        rdata <= mem[addr];
    end

endmodule

// File: design/hostBridge.sv
module hostBridge #(
    parameter int memAddrBits = 10
) (
    input  logic          clock,
    input  logic          rst,
    input  logic [31:0]   awaddr,
    input  logic          awvalid,
    output logic          awready,
    input  logic [31:0]   wdata,
    input  logic          wvalid,
    output logic          wready,
    output logic          bvalid,
    input  logic          bready,
    output logic [1:0]    bresp,
    input  logic [31:0]   araddr,
    input  logic          arvalid,
    output logic          arready,
    output logic          rvalid,
    input  logic          rready,
    output logic [31:0]   rdata,
    output logic [1:0]    rresp,
    input  logic          halted,
    input  logic          memGrant,
    input  rvPkg::memRspT memRsp,
    output rvPkg::memReqT memReq,
    output logic          coreRun
);

    logic wrAccept;
    logic rdAccept;
    // ram read granted, waiting for its data
    logic rdWait;

    // one ram request in flight at a time
    assign wrAccept = awvalid && wvalid && !bvalid && !memReq.valid;
    assign rdAccept = arvalid && !rvalid && !rdWait && !memReq.valid && !wrAccept;

    // address and data taken together
    assign awready = wrAccept;
    assign wready  = wrAccept;
    assign arready = rdAccept;
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;

    always_ff @(posedge clock) begin
        if (rst) begin
            memReq  <= '0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            rdWait  <= 1'b0;
            coreRun <= 1'b0;
        end else begin
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (wrAccept) begin
                if (awaddr == rvPkg::CTRL_ADDR) begin
                    // control writes answer at once
                    coreRun <= wdata[0];
                    bvalid  <= 1'b1;
                end else begin
                    memReq <= '{valid: 1'b1, write: 1'b1,
                                wordAddr: 30'(awaddr[memAddrBits+1:2]), wdata: wdata};
                end
            end
            if (rdAccept) begin
                if (araddr == rvPkg::CTRL_ADDR) begin
                    rdata  <= {30'd0, halted, coreRun};
                    rvalid <= 1'b1;
                end else begin
                    memReq <= '{valid: 1'b1, write: 1'b0,
                                wordAddr: 30'(araddr[memAddrBits+1:2]), wdata: 32'd0};
                end
            end
            // request held until the arbiter grants it
            if (memReq.valid && memGrant) begin
                memReq.valid <= 1'b0;
                if (memReq.write) begin
                    bvalid <= 1'b1;
                end else begin
                    rdWait <= 1'b1;
                end
            end
            if (rdWait && memRsp.rvalid) begin
                rdata  <= memRsp.rdata;
                rvalid <= 1'b1;
                rdWait <= 1'b0;
            end
        end
    end

endmodule

// File: design/rvSystem.sv
module rvSystem #(
    parameter int          memAddrBits = 10,
    parameter logic [31:0] resetPc     = 32'h0000_0000
) (
    input  logic        clock,
    input  logic        rst,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp
);

    rvPkg::ctrlStateT currentState;
    rvPkg::aluOpT     operation;
    rvPkg::memReqT    coreReq;
    rvPkg::memReqT    hostReq;
    rvPkg::memReqT    ramReq;
    rvPkg::memRspT    coreRsp;
    rvPkg::memRspT    hostRsp;
    logic [31:0] ramRdata;
    logic [29:0] coreAddr;
    logic [31:0] coreWdata;
    logic [6:0]  opcode;
    logic [3:0]  funct;
    logic zero;
    logic pcWrite;
    logic irWrite;
    logic regWrite;
    logic aluSrcImm;
    logic memToReg;
    logic memValid;
    logic memWrite;
    logic halted;
    logic coreRun;
    logic coreGrant;
    logic hostGrant;

    // core request from control enables and datapath fields
    assign coreReq = '{valid: memValid, write: memWrite, wordAddr: coreAddr, wdata: coreWdata};

    controlUnit ctrl0 (
        .clock(clock), .rst(rst), .coreRun(coreRun), .opcode(opcode), .zero(zero),
        .memGrant(coreGrant), .memRvalid(coreRsp.rvalid), .currentState(currentState),
        .pcWrite(pcWrite), .irWrite(irWrite), .regWrite(regWrite), .aluSrcImm(aluSrcImm),
        .memToReg(memToReg), .memValid(memValid), .memWrite(memWrite), .halted(halted)
    );

    aluControl aluCtrl0 (
        .currentState(currentState), .opcode(opcode), .funct(funct), .operation(operation)
    );

    coreDatapath #(.resetPc(resetPc)) path0 (
        .clock(clock), .rst(rst), .pcWrite(pcWrite), .irWrite(irWrite),
        .regWrite(regWrite), .aluSrcImm(aluSrcImm), .memToReg(memToReg),
        .operation(operation), .memRsp(coreRsp), .wordAddr(coreAddr), .wdata(coreWdata),
        .opcode(opcode), .funct(funct), .zero(zero)
    );

    memArbiter arb0 (
        .clock(clock), .rst(rst), .coreReq(coreReq), .hostReq(hostReq), .ramRdata(ramRdata),
        .coreGrant(coreGrant), .hostGrant(hostGrant), .coreRsp(coreRsp), .hostRsp(hostRsp),
        .ramReq(ramReq)
    );

    sharedRam #(.memAddrBits(memAddrBits)) ram0 (
        .clock(clock), .req(ramReq), .rdata(ramRdata)
    );

    hostBridge #(.memAddrBits(memAddrBits)) bridge0 (
        .clock(clock), .rst(rst), .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready),
        .bresp(bresp), .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp), .halted(halted),
        .memGrant(hostGrant), .memRsp(hostRsp), .memReq(hostReq), .coreRun(coreRun)
    );

endmodule

// File: test/rvSystemTb.sv
module rvSystemTb;

    timeunit 1ns;
    timeprecision 100ps;

    // about four times the summed worst case of all tests
    localparam int TIMEOUT_CYCLES = 20000;
    localparam logic [31:0] DATA_BASE = 32'h0000_0200;
    localparam logic [31:0] RESULT_BASE = 32'h0000_0240;
    localparam logic [31:0] BRANCH_BASE = 32'h0000_0260;
    localparam logic [31:0] HOST_BASE = 32'h0000_0300;

    logic        clock;
    logic        rst;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;

    logic [31:0] rngState;
    logic [31:0] prog [$];
    // immediates of the OP_IMM program, indexed like the ALU ops
    logic [11:0] imms [7];
    int cycleCount = 0;

    rvSystem #(.memAddrBits(10), .resetPc(32'h0000_0000)) dut0 (
        .clock(clock), .rst(rst), .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready),
        .bresp(bresp), .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // instruction encoders, straight from the isa formats
    function automatic logic [31:0] encodeR(input logic [6:0] funct7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] funct3,
                                            input logic [4:0] rd);
        encodeR = {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] funct3, input logic [4:0] rd,
                                            input logic [6:0] opcode);
        encodeI = {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] encodeS(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        encodeS = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encodeB(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        encodeB = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // op index: add sub and or xor slt sltu
    function automatic logic [2:0] opFunct3(input int k);
        case (k)
            2: opFunct3 = 3'b111;
            3: opFunct3 = 3'b110;
            4: opFunct3 = 3'b100;
            5: opFunct3 = 3'b010;
            6: opFunct3 = 3'b011;
            default: opFunct3 = 3'b000;
        endcase
    endfunction

    // reference model of the rv32i results
    function automatic logic [31:0] modelOp(input int k, input logic [31:0] a,
                                            input logic [31:0] b);
        case (k)
            1: modelOp = a - b;
            2: modelOp = a & b;
            3: modelOp = a | b;
            4: modelOp = a ^ b;
            5: modelOp = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6: modelOp = (a < b) ? 32'd1 : 32'd0;
            default: modelOp = a + b;
        endcase
    endfunction

    task automatic checkWord(input string testName, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch %s expected %h actual %h", testName, expected, actual);
            $display("Test failed");
            $fatal(1, "value check did not hold");
        end
    endtask

    task automatic applyReset;
        rst = 1'b1;
        repeat (4) @(posedge clock);
        #1;
        rst = 1'b0;
    endtask

    task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data, input int bDelay);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // address and data go in the same cycle
        @(posedge clock);
        while (!(awready && wready)) @(posedge clock);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (bDelay) begin
            @(posedge clock);
            #1;
        end
        bready = 1'b1;
        @(posedge clock);
        while (!bvalid) @(posedge clock);
        checkWord("write response", 32'd0, {30'd0, bresp});
        #1;
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [31:0] addr, input int rDelay, output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        @(posedge clock);
        while (!arready) @(posedge clock);
        #1;
        arvalid = 1'b0;
        // rvalid must hold while rready stays low
        repeat (rDelay) begin
            @(posedge clock);
            #1;
        end
        rready = 1'b1;
        @(posedge clock);
        while (!rvalid) @(posedge clock);
        data = rdata;
        checkWord("read response", 32'd0, {30'd0, rresp});
        #1;
        rready = 1'b0;
    endtask

    task automatic buildAluProgram(input logic immForm);
        prog.delete();
        // lw x1 and x2 from the operand words
        prog.push_back(encodeI(DATA_BASE[11:0], 5'd0, 3'b010, 5'd1, rvPkg::LOAD));
        prog.push_back(encodeI(DATA_BASE[11:0] + 12'd4, 5'd0, 3'b010, 5'd2, rvPkg::LOAD));
        for (int k = 0; k < 7; k++) begin
            if (!immForm) begin
                prog.push_back(encodeR((k == 1) ? 7'h20 : 7'h00, 5'd2, 5'd1, opFunct3(k), 5'd3));
            end else if (k != 1) begin
                prog.push_back(encodeI(imms[k], 5'd1, opFunct3(k), 5'd3, rvPkg::OP_IMM));
            end
            if (!immForm || k != 1) begin
                prog.push_back(encodeS(RESULT_BASE[11:0] + 12'(4 * k), 5'd3, 5'd0));
            end
        end
        // ecall
        prog.push_back(32'h0000_0073);
    endtask

    task automatic loadAndStart;
        for (int i = 0; i < prog.size(); i++) begin
            axiWrite(32'(4 * i), prog[i], 0);
        end
        axiWrite(rvPkg::CTRL_ADDR, 32'd1, 0);
    endtask

    task automatic waitHalted;
        logic [31:0] status;
        status = 32'd0;
        while (!status[1]) begin
            axiRead(rvPkg::CTRL_ADDR, 0, status);
        end
    endtask

    task automatic checkAluResults(input string testName, input logic [31:0] a,
                                   input logic [31:0] b, input logic immForm);
        logic [31:0] value;
        logic [31:0] operandB;
        for (int k = 0; k < 7; k++) begin
            if (!immForm || k != 1) begin
                operandB = immForm ? {{20{imms[k][11]}}, imms[k]} : b;
                axiRead(RESULT_BASE + 32'(4 * k), 0, value);
                checkWord(testName, modelOp(k, a, operandB), value);
            end
        end
    endtask

    initial begin
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] value;
        logic [11:0] loopCount;
        logic [31:0] hostData [16];
        rngState = 32'h440c_fec1;
        awaddr = 32'd0;
        awvalid = 1'b0;
        wdata = 32'd0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = 32'd0;
        arvalid = 1'b0;
        rready = 1'b0;
        applyReset();

        // responses idle, control register clear
        checkWord("reset bvalid", 32'd0, {31'd0, bvalid});
        checkWord("reset rvalid", 32'd0, {31'd0, rvalid});
        axiRead(rvPkg::CTRL_ADDR, 0, value);
        checkWord("reset control", 32'd0, value);

        // host memory path with response back-pressure
        for (int i = 0; i < 8; i++) begin
            rngState = xorshift(rngState);
            hostData[i] = rngState;
            axiWrite(32'h100 + 32'(4 * i), hostData[i], int'(rngState[1:0]));
        end
        for (int i = 0; i < 8; i++) begin
            rngState = xorshift(rngState);
            axiRead(32'h100 + 32'(4 * i), int'(rngState[3:2]), value);
            checkWord("host memory", hostData[i], value);
        end

        rngState = xorshift(rngState);
        opA = rngState;
        rngState = xorshift(rngState);
        opB = rngState;
        axiWrite(DATA_BASE, opA, 0);
        axiWrite(DATA_BASE + 32'd4, opB, 0);
        buildAluProgram(1'b0);
        loadAndStart();
        waitHalted();
        checkAluResults("register ops", opA, opB, 1'b0);

        // odd slots and the sltiu slot get negative immediates
        for (int k = 0; k < 7; k++) begin
            rngState = xorshift(rngState);
            imms[k] = rngState[11:0] | ((k % 2 == 1 || k == 6) ? 12'h800 : 12'h000);
        end
        applyReset();
        buildAluProgram(1'b1);
        loadAndStart();
        waitHalted();
        checkAluResults("immediate ops", opA, opB, 1'b1);

        rngState = xorshift(rngState);
        loopCount = 12'd3 + {9'd0, rngState[2:0]};
        applyReset();
        prog.delete();
        prog.push_back(encodeI(loopCount, 5'd0, 3'b000, 5'd1, rvPkg::OP_IMM));
        prog.push_back(encodeI(12'd0, 5'd0, 3'b000, 5'd2, rvPkg::OP_IMM));
        // loop head exits to the untaken beq when x1 reaches zero
        prog.push_back(encodeB(13'd16, 5'd0, 5'd1));
        prog.push_back(encodeI(12'hfff, 5'd1, 3'b000, 5'd1, rvPkg::OP_IMM));
        prog.push_back(encodeI(12'd1, 5'd2, 3'b000, 5'd2, rvPkg::OP_IMM));
        // back to loop head, offset -12
        prog.push_back(encodeB(13'h1ff4, 5'd0, 5'd0));
        prog.push_back(encodeB(13'd8, 5'd2, 5'd1));
        prog.push_back(encodeI(12'h055, 5'd0, 3'b000, 5'd3, rvPkg::OP_IMM));
        prog.push_back(encodeS(BRANCH_BASE[11:0], 5'd1, 5'd0));
        prog.push_back(encodeS(BRANCH_BASE[11:0] + 12'd4, 5'd2, 5'd0));
        prog.push_back(encodeS(BRANCH_BASE[11:0] + 12'd8, 5'd3, 5'd0));
        prog.push_back(32'h0000_0073);
        loadAndStart();
        waitHalted();
        axiRead(BRANCH_BASE, 0, value);
        checkWord("branch counter", 32'd0, value);
        axiRead(BRANCH_BASE + 32'd4, 0, value);
        checkWord("branch tally", {20'd0, loopCount}, value);
        axiRead(BRANCH_BASE + 32'd8, 0, value);
        checkWord("branch not taken", 32'h55, value);

        // host traffic while the core runs the register program
        rngState = xorshift(rngState);
        opA = rngState;
        rngState = xorshift(rngState);
        opB = rngState;
        applyReset();
        axiWrite(DATA_BASE, opA, 0);
        axiWrite(DATA_BASE + 32'd4, opB, 0);
        buildAluProgram(1'b0);
        loadAndStart();
        for (int i = 0; i < 16; i++) begin
            rngState = xorshift(rngState);
            hostData[i] = rngState;
            axiWrite(HOST_BASE + 32'(4 * i), hostData[i], 0);
            axiRead(HOST_BASE + 32'(4 * i), 0, value);
            checkWord("arbitration host", hostData[i], value);
        end
        waitHalted();
        checkAluResults("arbitration core", opA, opB, 1'b0);
        for (int i = 0; i < 16; i++) begin
            axiRead(HOST_BASE + 32'(4 * i), 0, value);
            checkWord("arbitration host final", hostData[i], value);
        end

        $display("Test passed");
        $finish;
    end

endmodule

// File: rvSystem.f
design/rvPkg.sv
design/aluControl.sv
design/alu.sv
design/controlUnit.sv
design/coreDatapath.sv
design/memArbiter.sv
design/sharedRam.sv
design/hostBridge.sv
design/rvSystem.sv
test/rvSystemTb.sv
